// ==== vlog.f ====
exec_pkg.sv
retire_pkg.sv
alu_unit.sv
brnch_unit.sv
ex_writeback.sv
exec_cluster_top.sv
exec_sva.sv
exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== exec_tb.sv ====
`default_nettype none

module exec_tb
    import exec_pkg::*;
    import retire_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_OPS     = 2000;
    localparam int RST_CYC   = 16;
    localparam int CYC_LIMIT = N_OPS + RST_CYC + 100;

    logic               clk_i, rst_n_i, flush_i;
    logic               alu_valid_i, alu_wb_en_i, brnch_valid_i, brnch_wb_en_i;
    logic               brnch_pred_tkn_i, brnch_btb_present_i, brnch_btb_way_i;
    alu_op_e            alu_op_i;
    brnch_op_e          brnch_op_i;
    logic [XLEN-1:0]    alu_src_a_i, alu_src_b_i, brnch_src_a_i, brnch_src_b_i;
    logic [XLEN-1:0]    brnch_imm_i, brnch_pred_target_i, p0_we_data_o;
    logic [ROB_W-1:0]   alu_rob_id_i, brnch_rob_id_i, cmp_rob_o, excp_rob_o;
    logic [PREG_W-1:0]  alu_dest_i, brnch_dest_i, p0_we_dest_o;
    logic [VPC_W-1:0]   brnch_vpc_i, btb_upd_vpc_o;
    logic [CNTR_W-1:0]  brnch_cntr_i, btb_upd_cntr_o;
    logic [TGT_W-1:0]   btb_upd_target_o;
    logic               p0_wen_o, cmp_v_o, excp_valid_o, btb_upd_v_o;
    logic               btb_upd_tkn_o, btb_upd_present_o, btb_upd_way_o;
    excp_code_e         excp_code_o;
    btb_type_e          btb_upd_type_o;

    typedef struct packed {
        logic [1:0]         kind;               // 0 idle, 1 ALU, 2 branch
        logic               wb_en;
        logic [XLEN-1:0]    data;
        logic [PREG_W-1:0]  dest;
        logic [ROB_W-1:0]   rob;
        logic               excp;
        excp_code_e         code;
        btb_type_e          btype;
        logic [CNTR_W-1:0]  cntr;
        logic [TGT_W-1:0]   tgt;
        logic               tkn;
        logic [VPC_W-1:0]   vpc;
        logic               present;
        logic               way;
    } exp_t;

    exp_t   pend;                               // Issued last cycle
    exp_t   nxt;                                // Issued this cycle
    int     cyc_cnt = 0;

    exec_cluster_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    function automatic logic [XLEN-1:0] alu_model(input alu_op_e op,
                                                  input logic [XLEN-1:0] a, b);
        logic [4:0]         sh;
        logic [XLEN-1:0]    fill;
        sh   = b[4:0];
        fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;     // Sign copies for SRA
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + XLEN'(1);
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << sh;
            ALU_SRL: return a >> sh;
            ALU_SRA: return (a >> sh) | fill;
            ALU_SLT: return XLEN'($signed(a) < $signed(b));
            default: return XLEN'(a < b);
        endcase
    endfunction

    function automatic logic taken_model(input brnch_op_e op, input logic [XLEN-1:0] a, b);
        case (op)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return !($signed(a) < $signed(b));
            BR_BLTU: return a < b;
            BR_BGEU: return !(a < b);
            default: return 1'b1;               // JAL and JALR always jump
        endcase
    endfunction

    task automatic check_wb(input logic exp_v, input logic [XLEN-1:0] data,
                            input logic [PREG_W-1:0] dest);
        if (p0_wen_o !== exp_v)
            report_mismatch($sformatf("p0_wen_o %b, expected %b", p0_wen_o, exp_v));
        else if (exp_v && (p0_we_data_o !== data || p0_we_dest_o !== dest))
            report_mismatch($sformatf("write %h to p%0d, expected %h to p%0d",
                                      p0_we_data_o, p0_we_dest_o, data, dest));
    endtask

    task automatic check_cmp(input logic exp_v, input logic [ROB_W-1:0] rob);
        if (cmp_v_o !== exp_v || (exp_v && cmp_rob_o !== rob))
            report_mismatch($sformatf("completion %b rob %0d, expected %b rob %0d",
                                      cmp_v_o, cmp_rob_o, exp_v, rob));
    endtask

    task automatic check_excp(input logic exp_v, input logic [ROB_W-1:0] rob,
                              input excp_code_e code);
        if (excp_valid_o !== exp_v
                || (exp_v && (excp_rob_o !== rob || excp_code_o !== code)))
            report_mismatch($sformatf("exception %b rob %0d code %0d, expected %b rob %0d code %0d",
                                      excp_valid_o, excp_rob_o, excp_code_o, exp_v, rob, code));
    endtask

    task automatic check_btb(input logic exp_v, input btb_type_e btype,
                             input logic [CNTR_W-1:0] cntr, input logic [TGT_W-1:0] tgt,
                             input logic tkn, input logic [VPC_W-1:0] vpc,
                             input logic present, input logic way);
        if (btb_upd_v_o !== exp_v)
            report_mismatch($sformatf("btb_upd_v_o %b, expected %b", btb_upd_v_o, exp_v));
        else if (exp_v && (btb_upd_type_o !== btype || btb_upd_cntr_o !== cntr
                           || btb_upd_target_o !== tgt || btb_upd_tkn_o !== tkn))
            report_mismatch($sformatf("BTB type %0d cntr %0d tgt %h tkn %b, expected %0d %0d %h %b",
                                      btb_upd_type_o, btb_upd_cntr_o, btb_upd_target_o,
                                      btb_upd_tkn_o, btype, cntr, tgt, tkn));
        else if (exp_v && (btb_upd_vpc_o !== vpc || btb_upd_present_o !== present
                           || btb_upd_way_o !== way))
            report_mismatch($sformatf("BTB pc %h present %b way %b, expected %h %b %b",
                                      btb_upd_vpc_o, btb_upd_present_o, btb_upd_way_o,
                                      vpc, present, way));
    endtask

    task automatic issue_alu();
        alu_op_i     = alu_op_e'($urandom_range(9, 0));
        alu_src_a_i  = $urandom;
        alu_src_b_i  = $urandom;
        alu_rob_id_i = ROB_W'($urandom);
        alu_dest_i   = PREG_W'($urandom);
        alu_wb_en_i  = 1'($urandom);
        alu_valid_i  = 1'b1;
        nxt.kind  = 2'd1;
        nxt.wb_en = alu_wb_en_i;
        nxt.data  = alu_model(alu_op_i, alu_src_a_i, alu_src_b_i);
        nxt.dest  = alu_dest_i;
        nxt.rob   = alu_rob_id_i;
    endtask

    task automatic issue_branch();
        logic [XLEN-1:0]    tgt;
        logic               tkn;
        brnch_op_i          = brnch_op_e'($urandom_range(7, 0));
        brnch_src_a_i       = $urandom;
        brnch_src_b_i       = ($urandom_range(3, 0) == 0) ? brnch_src_a_i : $urandom;
        brnch_imm_i         = $urandom & ~32'h3;
        brnch_vpc_i         = VPC_W'($urandom);
        brnch_rob_id_i      = ROB_W'($urandom);
        brnch_dest_i        = PREG_W'($urandom);
        brnch_wb_en_i       = 1'($urandom);
        brnch_cntr_i        = CNTR_W'($urandom);
        brnch_btb_present_i = 1'($urandom);
        brnch_btb_way_i     = 1'($urandom);
        if ($urandom_range(3, 0) == 0)
            brnch_imm_i[1] = 1'b1;              // Misaligned when taken
        if (brnch_op_i == BR_JALR)
            brnch_src_a_i[1:0] = 2'b00;
        tkn = taken_model(brnch_op_i, brnch_src_a_i, brnch_src_b_i);
        if (brnch_op_i == BR_JALR)
            tgt = (brnch_src_a_i + brnch_imm_i) & ~XLEN'(1);
        else
            tgt = {brnch_vpc_i, 2'b00} + brnch_imm_i;
        brnch_pred_tkn_i    = tkn;
        brnch_pred_target_i = tgt;
        if ($urandom_range(9, 0) < 4) begin     // Front end guessed blind
            brnch_pred_tkn_i = 1'($urandom);
            if ($urandom_range(1, 0) == 0)
                brnch_pred_target_i = $urandom;
        end
        brnch_valid_i = 1'b1;
        nxt.kind    = 2'd2;
        nxt.wb_en   = brnch_wb_en_i;
        nxt.data    = {brnch_vpc_i, 2'b00} + XLEN'(4);
        nxt.dest    = brnch_dest_i;
        nxt.rob     = brnch_rob_id_i;
        nxt.tkn     = tkn;
        nxt.tgt     = tgt[XLEN-1:2];
        nxt.vpc     = brnch_vpc_i;
        nxt.present = brnch_btb_present_i;
        nxt.way     = brnch_btb_way_i;
        nxt.excp    = (tkn != brnch_pred_tkn_i) || (tkn && tgt != brnch_pred_target_i)
                      || (tkn && tgt[1:0] != 2'b00);
        nxt.code    = (tkn && tgt[1:0] != 2'b00) ? EXCP_MISALIGN : EXCP_MISPREDICT;
        nxt.cntr    = tkn ? ((brnch_cntr_i == 2'd3) ? 2'd3 : brnch_cntr_i + 2'd1)
                          : ((brnch_cntr_i == 2'd0) ? 2'd0 : brnch_cntr_i - 2'd1);
        nxt.btype   = (brnch_op_i == BR_JAL)  ? BTB_DIRECT :
                      (brnch_op_i == BR_JALR) ? BTB_INDIRECT : BTB_COND;
    endtask

    task automatic drive_cycle(input bit allow);
        int unsigned kind;
        kind          = allow ? $urandom_range(2, 0) : 0;
        flush_i       = ($urandom_range(99, 0) < 5);
        alu_valid_i   = 1'b0;
        brnch_valid_i = 1'b0;
        nxt           = '0;
        if (kind == 1)
            issue_alu();
        else if (kind == 2)
            issue_branch();
    endtask

    always @(posedge clk_i) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cyc_cnt);
            abort_run();
        end
    end

    initial begin
        logic live;
        void'($urandom(45));
        issue_alu();                            // Gives every input a value
        issue_branch();
        alu_valid_i   = 1'b0;
        brnch_valid_i = 1'b0;
        flush_i       = 1'b0;
        pend          = '0;
        rst_n_i       = 1'b1;
        #1;
        rst_n_i = 1'b0;
        repeat (RST_CYC) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        for (int i = 0; i <= N_OPS; i++) begin
            @(posedge clk_i);
            #2;
            drive_cycle(i < N_OPS);             // Last round only drains
            @(negedge clk_i);
            live = (pend.kind != 2'd0) && !flush_i;
            check_wb(live && pend.wb_en, pend.data, pend.dest);
            check_cmp(live, pend.rob);
            check_excp(live && pend.kind == 2'd2 && pend.excp, pend.rob, pend.code);
            check_btb(live && pend.kind == 2'd2, pend.btype, pend.cntr, pend.tgt,
                      pend.tkn, pend.vpc, pend.present, pend.way);
            pend = nxt;
            if (flush_i)
                pend.kind = 2'd0;               // Dropped at issue
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exec_sva.sv ====
`default_nettype none

module exec_sva (
    input   wire logic  clk_i,
    input   wire logic  rst_n_i,
    input   wire logic  flush_i,
    input   wire logic  p0_wen_o,
    input   wire logic  cmp_v_o,
    input   wire logic  excp_valid_o,
    input   wire logic  btb_upd_v_o
);

    timeunit 1ns;
    timeprecision 100ps;

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> !(p0_wen_o || cmp_v_o || excp_valid_o || btb_upd_v_o))
        else $error("valid output high while reset is held");

    // Flush masks in the same cycle
    a_flush_mask: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> (!p0_wen_o && !excp_valid_o))
        else $error("write or exception not masked by flush");

    a_excp_trains: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        excp_valid_o |-> btb_upd_v_o)
        else $error("exception without a BTB update");

endmodule

bind exec_cluster_top exec_sva i_sva (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .p0_wen_o     (p0_wen_o),
    .cmp_v_o      (cmp_v_o),
    .excp_valid_o (excp_valid_o),
    .btb_upd_v_o  (btb_upd_v_o)
);

`default_nettype wire

// ==== exec_cluster_top.sv ====
`default_nettype none

module exec_cluster_top
    import exec_pkg::*;
    import retire_pkg::*;
(
    input   wire logic                      clk_i,
    input   wire logic                      rst_n_i,
    input   wire logic                      flush_i,

    input   wire logic                      alu_valid_i,
    input   wire alu_op_e                   alu_op_i,
    input   wire logic [XLEN-1:0]           alu_src_a_i,
    input   wire logic [XLEN-1:0]           alu_src_b_i,
    input   wire logic [ROB_W-1:0]          alu_rob_id_i,
    input   wire logic [PREG_W-1:0]         alu_dest_i,
    input   wire logic                      alu_wb_en_i,

    input   wire logic                      brnch_valid_i,
    input   wire brnch_op_e                 brnch_op_i,
    input   wire logic [XLEN-1:0]           brnch_src_a_i,
    input   wire logic [XLEN-1:0]           brnch_src_b_i,
    input   wire logic [XLEN-1:0]           brnch_imm_i,
    input   wire logic [VPC_W-1:0]          brnch_vpc_i,
    input   wire logic [ROB_W-1:0]          brnch_rob_id_i,
    input   wire logic [PREG_W-1:0]         brnch_dest_i,
    input   wire logic                      brnch_wb_en_i,
    input   wire logic                      brnch_pred_tkn_i,
    input   wire logic [XLEN-1:0]           brnch_pred_target_i,
    input   wire logic [CNTR_W-1:0]         brnch_cntr_i,
    input   wire logic                      brnch_btb_present_i,
    input   wire logic                      brnch_btb_way_i,

    output  wire logic [XLEN-1:0]           p0_we_data_o,
    output  wire logic [PREG_W-1:0]         p0_we_dest_o,
    output  wire logic                      p0_wen_o,
    output  wire logic [ROB_W-1:0]          cmp_rob_o,
    output  wire logic                      cmp_v_o,
    output  wire logic [ROB_W-1:0]          excp_rob_o,
    output  wire excp_code_e                excp_code_o,
    output  wire logic                      excp_valid_o,

    output  wire logic [VPC_W-1:0]          btb_upd_vpc_o,
    output  wire logic [TGT_W-1:0]          btb_upd_target_o,
    output  wire logic [CNTR_W-1:0]         btb_upd_cntr_o,
    output  wire logic                      btb_upd_tkn_o,
    output  wire btb_type_e                 btb_upd_type_o,
    output  wire logic                      btb_upd_present_o,
    output  wire logic                      btb_upd_way_o,
    output  wire logic                      btb_upd_v_o
);

    logic [XLEN-1:0]    alu_result;
    logic [PREG_W-1:0]  alu_dest;
    logic               alu_wb_valid;
    logic [ROB_W-1:0]   alu_rob_id;
    logic               alu_cmp_valid;

    logic [XLEN-1:0]    brnch_result;
    logic [PREG_W-1:0]  brnch_dest;
    logic               brnch_wb_valid;
    logic [ROB_W-1:0]   brnch_rob_id;
    logic               brnch_cmp_valid;
    logic               brnch_excp_valid;
    excp_code_e         brnch_excp_code;
    logic               brnch_upd_valid;

    alu_unit u_alu (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .valid_i     (alu_valid_i),
        .op_i        (alu_op_i),
        .src_a_i     (alu_src_a_i),
        .src_b_i     (alu_src_b_i),
        .rob_id_i    (alu_rob_id_i),
        .dest_i      (alu_dest_i),
        .wb_en_i     (alu_wb_en_i),
        .result_o    (alu_result),
        .dest_o      (alu_dest),
        .wb_valid_o  (alu_wb_valid),
        .rob_id_o    (alu_rob_id),
        .cmp_valid_o (alu_cmp_valid)
    );

    brnch_unit u_brnch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .valid_i       (brnch_valid_i),
        .op_i          (brnch_op_i),
        .src_a_i       (brnch_src_a_i),
        .src_b_i       (brnch_src_b_i),
        .imm_i         (brnch_imm_i),
        .vpc_i         (brnch_vpc_i),
        .rob_id_i      (brnch_rob_id_i),
        .dest_i        (brnch_dest_i),
        .wb_en_i       (brnch_wb_en_i),
        .pred_tkn_i    (brnch_pred_tkn_i),
        .pred_target_i (brnch_pred_target_i),
        .cntr_i        (brnch_cntr_i),
        .btb_present_i (brnch_btb_present_i),
        .btb_way_i     (brnch_btb_way_i),
        .result_o      (brnch_result),
        .dest_o        (brnch_dest),
        .wb_valid_o    (brnch_wb_valid),
        .rob_id_o      (brnch_rob_id),
        .cmp_valid_o   (brnch_cmp_valid),
        .excp_valid_o  (brnch_excp_valid),
        .excp_code_o   (brnch_excp_code),
        .upd_vpc_o     (btb_upd_vpc_o),
        .upd_target_o  (btb_upd_target_o),
        .upd_cntr_o    (btb_upd_cntr_o),
        .upd_tkn_o     (btb_upd_tkn_o),
        .upd_type_o    (btb_upd_type_o),
        .upd_present_o (btb_upd_present_o),
        .upd_way_o     (btb_upd_way_o),
        .upd_valid_o   (brnch_upd_valid)
    );

    assign btb_upd_v_o = brnch_upd_valid & ~flush_i;   // BTB must not train on killed ops

    ex_writeback u_wb (
        .flush_i            (flush_i),
        .alu_result_i       (alu_result),
        .alu_dest_i         (alu_dest),
        .alu_wb_valid_i     (alu_wb_valid),
        .alu_rob_id_i       (alu_rob_id),
        .alu_valid_i        (alu_cmp_valid),
        .brnch_result_i     (brnch_result),
        .brnch_dest_i       (brnch_dest),
        .brnch_wb_valid_i   (brnch_wb_valid),
        .brnch_rob_id_i     (brnch_rob_id),
        .brnch_valid_i      (brnch_cmp_valid),
        .brnch_excp_valid_i (brnch_excp_valid),
        .brnch_excp_code_i  (brnch_excp_code),
        .p0_we_data_o       (p0_we_data_o),
        .p0_we_dest_o       (p0_we_dest_o),
        .p0_wen_o           (p0_wen_o),
        .cmp_rob_o          (cmp_rob_o),
        .cmp_v_o            (cmp_v_o),
        .excp_rob_o         (excp_rob_o),
        .excp_code_o        (excp_code_o),
        .excp_valid_o       (excp_valid_o)
    );

endmodule

`default_nettype wire

// ==== ex_writeback.sv ====
`default_nettype none

module ex_writeback
    import exec_pkg::*;
    import retire_pkg::*;
(
    input   wire logic                      flush_i,

    input   wire logic [XLEN-1:0]           alu_result_i,
    input   wire logic [PREG_W-1:0]         alu_dest_i,
    input   wire logic                      alu_wb_valid_i,
    input   wire logic [ROB_W-1:0]          alu_rob_id_i,
    input   wire logic                      alu_valid_i,

    input   wire logic [XLEN-1:0]           brnch_result_i,
    input   wire logic [PREG_W-1:0]         brnch_dest_i,
    input   wire logic                      brnch_wb_valid_i,
    input   wire logic [ROB_W-1:0]          brnch_rob_id_i,
    input   wire logic                      brnch_valid_i,
    input   wire logic                      brnch_excp_valid_i,
    input   wire excp_code_e                brnch_excp_code_i,

    output  wire logic [XLEN-1:0]           p0_we_data_o,
    output  wire logic [PREG_W-1:0]         p0_we_dest_o,
    output  wire logic                      p0_wen_o,

    output  wire logic [ROB_W-1:0]          cmp_rob_o,
    output  wire logic                      cmp_v_o,

    output  wire logic [ROB_W-1:0]          excp_rob_o,
    output  wire excp_code_e                excp_code_o,
    output  wire logic                      excp_valid_o
);

    // Single write port, branch wins over ALU
    assign p0_we_data_o = brnch_wb_valid_i ? brnch_result_i : alu_result_i;
    assign p0_we_dest_o = brnch_wb_valid_i ? brnch_dest_i : alu_dest_i;
    assign p0_wen_o     = (brnch_wb_valid_i | alu_wb_valid_i) & ~flush_i;

    // One completion per cycle to the ROB
    assign cmp_rob_o = brnch_valid_i ? brnch_rob_id_i : alu_rob_id_i;
    assign cmp_v_o   = (brnch_valid_i | alu_valid_i) & ~flush_i;

    assign excp_rob_o   = brnch_rob_id_i;           // Only branches raise
    assign excp_code_o  = brnch_excp_code_i;
    assign excp_valid_o = brnch_excp_valid_i & ~flush_i;

endmodule

`default_nettype wire

// ==== brnch_unit.sv ====
`default_nettype none

module brnch_unit
    import exec_pkg::*;
    import retire_pkg::*;
(
    input   wire logic                      clk_i,
    input   wire logic                      rst_n_i,
    input   wire logic                      flush_i,

    input   wire logic                      valid_i,
    input   wire brnch_op_e                 op_i,
    input   wire logic [XLEN-1:0]           src_a_i,
    input   wire logic [XLEN-1:0]           src_b_i,
    input   wire logic [XLEN-1:0]           imm_i,
    input   wire logic [VPC_W-1:0]          vpc_i,
    input   wire logic [ROB_W-1:0]          rob_id_i,
    input   wire logic [PREG_W-1:0]         dest_i,
    input   wire logic                      wb_en_i,
    input   wire logic                      pred_tkn_i,
    input   wire logic [XLEN-1:0]           pred_target_i,
    input   wire logic [CNTR_W-1:0]         cntr_i,
    input   wire logic                      btb_present_i,
    input   wire logic                      btb_way_i,

    output  logic [XLEN-1:0]                result_o,
    output  logic [PREG_W-1:0]              dest_o,
    output  logic                           wb_valid_o,
    output  logic [ROB_W-1:0]               rob_id_o,
    output  logic                           cmp_valid_o,
    output  logic                           excp_valid_o,
    output  excp_code_e                     excp_code_o,
    output  logic [VPC_W-1:0]               upd_vpc_o,
    output  logic [TGT_W-1:0]               upd_target_o,
    output  logic [CNTR_W-1:0]              upd_cntr_o,
    output  logic                           upd_tkn_o,
    output  btb_type_e                      upd_type_o,
    output  logic                           upd_present_o,
    output  logic                           upd_way_o,
    output  logic                           upd_valid_o
);

    logic [XLEN-1:0]    pc_byte;
    logic [XLEN-1:0]    jalr_sum;
    logic [XLEN-1:0]    target;
    logic               taken;
    logic               misalign;
    logic               mispredict;
    logic [CNTR_W-1:0]  cntr_nxt;
    btb_type_e          br_type;

    assign pc_byte  = {vpc_i, 2'b00};
    assign jalr_sum = src_a_i + imm_i;
    assign target   = (op_i == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_byte + imm_i;

    always_comb begin
        taken = 1'b0;
        case (op_i)
            BR_BEQ:  taken = src_a_i == src_b_i;
            BR_BNE:  taken = src_a_i != src_b_i;
            BR_BLT:  taken = $signed(src_a_i) < $signed(src_b_i);
            BR_BGE:  taken = $signed(src_a_i) >= $signed(src_b_i);
            BR_BLTU: taken = src_a_i < src_b_i;
            BR_BGEU: taken = src_a_i >= src_b_i;
            default: taken = 1'b1;              // JAL and JALR
        endcase
    end

    assign misalign   = taken & (|target[1:0]);
    assign mispredict = (taken != pred_tkn_i) | (taken & (target != pred_target_i));

    // Saturating bimodal counter
    always_comb begin
        cntr_nxt = cntr_i;
        if (taken && cntr_i != {CNTR_W{1'b1}})
            cntr_nxt = cntr_i + 1'b1;
        else if (!taken && cntr_i != '0)
            cntr_nxt = cntr_i - 1'b1;
    end

    assign br_type = (op_i == BR_JAL)  ? BTB_DIRECT :
                     (op_i == BR_JALR) ? BTB_INDIRECT : BTB_COND;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o   <= 1'b0;
            cmp_valid_o  <= 1'b0;
            excp_valid_o <= 1'b0;
            upd_valid_o  <= 1'b0;
        end else begin
            wb_valid_o   <= valid_i & wb_en_i & ~flush_i;
            cmp_valid_o  <= valid_i & ~flush_i;
            excp_valid_o <= valid_i & (mispredict | misalign) & ~flush_i;
            upd_valid_o  <= valid_i & ~flush_i;    // Every resolved branch trains
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o      <= pc_byte + XLEN'(4);     // Link value
            dest_o        <= dest_i;
            rob_id_o      <= rob_id_i;
            excp_code_o   <= misalign ? EXCP_MISALIGN : EXCP_MISPREDICT;
            upd_vpc_o     <= vpc_i;
            upd_target_o  <= target[XLEN-1:2];
            upd_cntr_o    <= cntr_nxt;
            upd_tkn_o     <= taken;
            upd_type_o    <= br_type;
            upd_present_o <= btb_present_i;
            upd_way_o     <= btb_way_i;
        end
    end

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`default_nettype none

module alu_unit
    import exec_pkg::*;
    import retire_pkg::*;
(
    input   wire logic                      clk_i,
    input   wire logic                      rst_n_i,
    input   wire logic                      flush_i,

    input   wire logic                      valid_i,
    input   wire alu_op_e                   op_i,
    input   wire logic [XLEN-1:0]           src_a_i,
    input   wire logic [XLEN-1:0]           src_b_i,
    input   wire logic [ROB_W-1:0]          rob_id_i,
    input   wire logic [PREG_W-1:0]         dest_i,
    input   wire logic                      wb_en_i,

    output  logic [XLEN-1:0]                result_o,
    output  logic [PREG_W-1:0]              dest_o,
    output  logic                           wb_valid_o,
    output  logic [ROB_W-1:0]               rob_id_o,
    output  logic                           cmp_valid_o
);

    logic [XLEN-1:0]    alu_res;
    logic [4:0]         shamt;
    logic               lt_s;
    logic               lt_u;

    assign shamt = src_b_i[4:0];                // RV32 shifts use 5 bits
    assign lt_s  = $signed(src_a_i) < $signed(src_b_i);
    assign lt_u  = src_a_i < src_b_i;

    always_comb begin
        alu_res = '0;
        case (op_i)
            ALU_ADD:  alu_res = src_a_i + src_b_i;
            ALU_SUB:  alu_res = src_a_i - src_b_i;
            ALU_AND:  alu_res = src_a_i & src_b_i;
            ALU_OR:   alu_res = src_a_i | src_b_i;
            ALU_XOR:  alu_res = src_a_i ^ src_b_i;
            ALU_SLL:  alu_res = src_a_i << shamt;
            ALU_SRL:  alu_res = src_a_i >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(src_a_i) >>> shamt);
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            default:  alu_res = '0;             // Unused encodings
        endcase
    end

    // Valid bits, an issue during flush is dropped
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o  <= 1'b0;
            cmp_valid_o <= 1'b0;
        end else begin
            wb_valid_o  <= valid_i & wb_en_i & ~flush_i;
            cmp_valid_o <= valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o <= alu_res;
            dest_o   <= dest_i;
            rob_id_o <= rob_id_i;
        end
    end

endmodule

`default_nettype wire

// ==== retire_pkg.sv ====
`default_nettype none

package retire_pkg;

    localparam int ROB_W  = 5;                  // 32 ROB entries
    localparam int PREG_W = 6;                  // 64 physical registers

    // Cause codes seen by the ROB, only the branch unit raises any today
    typedef enum logic [4:0] {
        EXCP_MISALIGN   = 5'd0,                 // Instruction address misaligned
        EXCP_MISPREDICT = 5'd16                 // Redirect the front end
    } excp_code_e;

endpackage

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int XLEN   = 32;
    localparam int VPC_W  = 30;                 // Byte pc bits 31..2
    localparam int CNTR_W = 2;                  // Bimodal counter
    localparam int TGT_W  = XLEN - 2;           // Target as held in the BTB

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } brnch_op_e;

    typedef enum logic [1:0] {
        BTB_COND     = 2'd0,
        BTB_DIRECT   = 2'd1,
        BTB_INDIRECT = 2'd2
    } btb_type_e;

endpackage

`default_nettype wire
